// ==== src.f ====
+incdir+hdl
hdl/mipsPkg.sv
hdl/controlDecoder.sv
hdl/programCounter.sv
hdl/registerFile.sv
hdl/executeUnit.sv
hdl/singleCycleMips.sv
sim/memModel.sv
sim/mipsTb.sv

// ==== Makefile ====
# Verilator build for the single-cycle MIPS core and its testbench

VERILATOR  ?= verilator
TOP        := mipsTb
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides, the run passes only if it printed the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/mips_tests.txt ====
// program: 1 <byte addr> <instr>  | trace: 2 <pc> <wbData> <check wb> <we> <memAddr> <wdata>
// end: EE. data memory word i starts as 01010101 * (i+1), unloaded words are j-to-self
1 00 8C010000 // lw  r1, 0(r0)
1 04 8C020004 // lw  r2, 4(r0)
1 08 00221820 // add r3, r1, r2
1 0C 00412022 // sub r4, r2, r1
1 10 00232824 // and r5, r1, r3
1 14 00223025 // or  r6, r1, r2
1 18 0022382A // slt r7, r1, r2
1 1C 0041402A // slt r8, r2, r1
1 20 00220020 // add r0, r1, r2
1 24 00014820 // add r9, r0, r1
1 28 AC030014 // sw  r3, 20(r0)
1 2C 8C0A0014 // lw  r10, 20(r0)
1 30 10240001 // beq r1, r4, +1
1 38 10220005 // beq r1, r2, +5
1 3C 0C000013 // jal 0x4C
1 4C 03E06020 // add r12, r31, r0
1 50 00224827 // unknown funct into r9
1 54 01206820 // add r13, r9, r0
1 58 01C17020 // add r14, r14, r1
1 5C 11C1FFFE // beq r14, r1, -2
1 60 0800001B // j   0x6C
1 6C 01C37825 // or  r15, r14, r3
2 00 01010101 1 0 0 0
2 04 02020202 1 0 0 0
2 08 03030303 1 0 0 0
2 0C 01010101 1 0 0 0
2 10 01010101 1 0 0 0
2 14 03030303 1 0 0 0
2 18 00000001 1 0 0 0
2 1C 00000000 1 0 0 0
2 20 03030303 1 0 0 0
2 24 01010101 1 0 0 0
2 28 00000014 0 1 05 03030303
2 2C 03030303 1 0 0 0
2 30 00000000 0 0 0 0
2 38 00000000 0 0 0 0
2 3C 00000044 1 0 0 0
2 4C 00000044 1 0 0 0
2 50 00000000 0 0 0 0
2 54 01010101 1 0 0 0
2 58 01010101 1 0 0 0
2 5C 00000000 0 0 0 0
2 58 02020202 1 0 0 0
2 5C 00000000 0 0 0 0
2 60 00000000 0 0 0 0
2 6C 03030303 1 0 0 0
2 70 00000000 0 0 0 0
2 70 00000000 0 0 0 0
EE

// ==== sim/mipsTb.sv ====
/*
 * Testbench for the single-cycle MIPS core.
 * Reads program words and the per-cycle expected trace from
 * sim/mips_tests.txt, runs the core and checks every cycle.
 */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsTb import mipsPkg::*; ();

  localparam int ClkHalf     = 50;
  localparam int ResetCycles = 8;
  // sample point, 10 ns before the next rising edge
  localparam int CheckDelay  = 90;
  localparam int MaxCycles   = 200;
  localparam int TestWords   = 512;

  // record tags in the data file
  localparam word_t TagProg  = 32'h0000_0001;
  localparam word_t TagTrace = 32'h0000_0002;
  localparam word_t TagEnd   = 32'h0000_00EE;

  logic                    clk;
  logic                    rst;
  word_t                   instr;
  word_t                   instrAddr;
  word_t                   memReadData;
  logic [`DMEM_ADDR_W-1:0] memAddr;
  word_t                   memWriteData;
  logic                    memWriteEn;
  word_t                   wbData;

  word_t tests [TestWords];
  int    checkErrors;
  int    timeoutErrors;

  always #(ClkHalf) clk = ~clk;

  // ==================================================
  // DUT and memories
  // ==================================================
  singleCycleMips i_singleCycleMips (
    .clk          (clk),
    .rst          (rst),
    .instr        (instr),
    .instrAddr    (instrAddr),
    .memReadData  (memReadData),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memWriteEn   (memWriteEn),
    .wbData       (wbData)
  );

  memModel i_memModel (
    .clk          (clk),
    .rst          (rst),
    .instrAddr    (instrAddr),
    .instr        (instr),
    .memAddr      (memAddr),
    .memReadData  (memReadData),
    .memWriteData (memWriteData),
    .memWriteEn   (memWriteEn)
  );

  // ==================================================
  // helpers
  // ==================================================
  task automatic compareWord(input string name, input word_t expected,
                             input word_t actual);
    assert (actual === expected) else begin
      checkErrors++;
      $display("Fail t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // program records come first, returns index of the first trace record
  task automatic loadProgram(output int next);
    int idx;
    idx = 0;
    i_memModel.clearMemories();
    while (idx + 2 < TestWords && tests[idx] === TagProg) begin
      i_memModel.loadInstr(tests[idx + 1], tests[idx + 2]);
      idx += 3;
    end
    next = idx;
  endtask

  // trace record: tag, pc, wbData, wb check flag, we, memAddr, memWriteData
  task automatic checkCycle(input int idx);
    compareWord("instrAddr", tests[idx + 1], instrAddr);
    if (tests[idx + 3] != '0) begin
      compareWord("wbData", tests[idx + 2], wbData);
    end
    compareWord("memWriteEn", tests[idx + 4], word_t'(memWriteEn));
    // store port only matters when a write happens
    if (tests[idx + 4] != '0) begin
      compareWord("memAddr", tests[idx + 5], word_t'(memAddr));
      compareWord("memWriteData", tests[idx + 6], memWriteData);
    end
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    int ptr;
    int cycle;
    bit done;
    clk           = 1'b0;
    rst           = 1'b0;
    checkErrors   = 0;
    timeoutErrors = 0;
    cycle         = 0;
    done          = 1'b0;
    $readmemh("sim/mips_tests.txt", tests);
    loadProgram(ptr);

    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b1;

    // one trace record per cycle until the end marker
    while (!done) begin
      #(CheckDelay);
      if (ptr < TestWords && tests[ptr] === TagEnd) begin
        done = 1'b1;
      end else if (cycle < MaxCycles && ptr + 6 < TestWords &&
                   tests[ptr] === TagTrace) begin
        checkCycle(ptr);
        ptr += 7;
        cycle++;
        @(posedge clk);
      end else begin
        timeoutErrors++;
        $display("Timeout: trace ended without the end marker after %0d cycles", cycle);
        done = 1'b1;
      end
    end

    $display("Errors: %0d mismatches, %0d timeouts", checkErrors, timeoutErrors);
    if (checkErrors == 0 && timeoutErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/memModel.sv ====
/*
 * Instruction and data memory models for the core testbench.
 * Both read asynchronously, data writes land on the rising edge.
 * Call clearMemories first, then loadInstr once per program word.
 */
`timescale 1ns/1ps
`include "mips_macros.svh"

module memModel import mipsPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  word_t                   instrAddr,
  output word_t                   instr,
  input  logic [`DMEM_ADDR_W-1:0] memAddr,
  output word_t                   memReadData,
  input  word_t                   memWriteData,
  input  logic                    memWriteEn
);

  localparam int ImemWords = 256;
  localparam int DmemWords = 1 << `DMEM_ADDR_W;

  word_t imem [ImemWords];
  word_t dmem [DmemWords];

  // ==================================================
  // loading
  // ==================================================
  task automatic clearMemories();
    for (int i = 0; i < ImemWords; i++) begin
      // j to its own address, a stray fetch parks the core
      imem[i] = {`OP_J, 26'(i)};
    end
    for (int i = 0; i < DmemWords; i++) begin
      // word i holds (i+1) copies of 01 per byte
      dmem[i] <= 32'h0101_0101 * (i + 1);
    end
  endtask

  task automatic loadInstr(input word_t addr, input word_t data);
    imem[addr[9:2]] = data;
  endtask

  // async reads
  assign instr       = imem[instrAddr[9:2]];
  assign memReadData = dmem[memAddr];

  // decoder sees the word at 0 during reset, so hold writes off
  always @(posedge clk) begin
    if (rst && memWriteEn) begin
      dmem[memAddr] <= memWriteData;
    end
  end

endmodule

// ==== hdl/singleCycleMips.sv ====
/*
 * Top of the single-cycle MIPS core.
 * Instruction and data memory live outside and answer within the
 * same cycle. wbData shows what the register file is offered.
 */
`timescale 1ns/1ps
`include "mips_macros.svh"

module singleCycleMips import mipsPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  word_t                   instr,
  output word_t                   instrAddr,
  input  word_t                   memReadData,
  output logic [`DMEM_ADDR_W-1:0] memAddr,
  output word_t                   memWriteData,
  output logic                    memWriteEn,
  output word_t                   wbData
);

  ctrlSig_t ctrl;
  regAddr_t rsAddr;
  regAddr_t rtAddr;
  regAddr_t rdAddr;
  regAddr_t destAddr;
  word_t    rsData;
  word_t    rtData;
  word_t    aluResult;
  word_t    immExt;
  word_t    linkAddr;
  logic     aluZero;

  // instruction fields
  assign rsAddr = instr[25:21];
  assign rtAddr = instr[20:16];
  assign rdAddr = instr[15:11];

  // ==================================================
  // control
  // ==================================================
  controlDecoder i_controlDecoder (
    .instr (instr),
    .ctrl  (ctrl)
  );

  programCounter i_programCounter (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .aluZero      (aluZero),
    .jumpIndex    (instr[25:0]),
    .branchOffset (immExt),
    .pc           (instrAddr),
    .linkAddr     (linkAddr)
  );

  // ==================================================
  // datapath
  // ==================================================
  // destination: r31 for jal, rd for R-type, rt for lw
  assign destAddr = ctrl.link   ? `LINK_REG :
                    ctrl.regDst ? rdAddr    : rtAddr;

  // write-back source
  assign wbData = ctrl.link     ? linkAddr    :
                  ctrl.memToReg ? memReadData : aluResult;

  registerFile i_registerFile (
    .clk       (clk),
    .rst       (rst),
    .readAddrA (rsAddr),
    .readAddrB (rtAddr),
    .writeAddr (destAddr),
    .writeEn   (ctrl.regWrite),
    .writeData (wbData),
    .readDataA (rsData),
    .readDataB (rtData)
  );

  executeUnit i_executeUnit (
    .ctrl        (ctrl),
    .operandA    (rsData),
    .regOperandB (rtData),
    .imm         (instr[15:0]),
    .result      (aluResult),
    .zero        (aluZero),
    .immExt      (immExt)
  );

  // data memory port, word address from the byte address
  assign memAddr      = aluResult[`DMEM_ADDR_W+1:2];
  assign memWriteData = rtData;
  assign memWriteEn   = ctrl.memWrite;

endmodule

// ==== hdl/executeUnit.sv ====
/*
 * Execute stage of the single-cycle core.
 * Sign-extends the immediate, picks the second operand and runs
 * the ALU. The zero flag only counts for a subtraction, so beq
 * is the only user.
 */
`timescale 1ns/1ps
`include "mips_macros.svh"

module executeUnit import mipsPkg::*; (
  input  ctrlSig_t    ctrl,
  input  word_t       operandA,
  input  word_t       regOperandB,
  input  logic [15:0] imm,
  output word_t       result,
  output logic        zero,
  output word_t       immExt
);

  word_t operandB;

  // ==================================================
  // operand preparation
  // ==================================================
  // copy bit 15 into the upper half
  assign immExt   = {{16{imm[15]}}, imm};

  // immediate for lw/sw, register otherwise
  assign operandB = ctrl.aluSrc ? immExt : regOperandB;

  // ==================================================
  // ALU
  // ==================================================
  always_comb begin
    case (ctrl.aluCtrl)
      `ALU_ADD: result = operandA + operandB;
      `ALU_SUB: result = operandA - operandB;
      `ALU_AND: result = operandA & operandB;
      `ALU_OR:  result = operandA | operandB;
      // unsigned compare
      `ALU_SLT: result = (operandA < operandB) ? 32'd1 : 32'd0;
      default:  result = '0;
    endcase
  end

  // equal operands on beq
  assign zero = (ctrl.aluCtrl == `ALU_SUB) && (result == '0);

endmodule

// ==== hdl/registerFile.sv ====
/*
 * General purpose register file, 32 x 32 bits.
 * Two asynchronous read ports and one write port on the clock edge.
 * Register 0 is never written and always reads as zero.
 */
`timescale 1ns/1ps

module registerFile import mipsPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  regAddr_t readAddrA,
  input  regAddr_t readAddrB,
  input  regAddr_t writeAddr,
  input  logic     writeEn,
  input  word_t    writeData,
  output word_t    readDataA,
  output word_t    readDataB
);

  word_t regs [32];

  // ==================================================
  // write port
  // ==================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // whole file cleared while in reset
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != 5'd0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // read ports
  // r0 forced to zero on read as well
  assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

endmodule

// ==== hdl/programCounter.sv ====
/*
 * Program counter register with next-address selection.
 * Jump wins over a taken beq, otherwise the address steps by 4.
 * Also supplies pc+8 as the jal return value.
 */
`timescale 1ns/1ps

module programCounter import mipsPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  ctrlSig_t    ctrl,
  input  logic        aluZero,
  input  logic [25:0] jumpIndex,
  input  word_t       branchOffset,
  output word_t       pc,
  output word_t       linkAddr
);

  word_t pcReg;
  word_t pcPlus4;
  word_t branchTarget;
  word_t jumpTarget;
  logic  branchTaken;

  assign pcPlus4      = pcReg + 32'd4;
  assign linkAddr     = pcReg + 32'd8;
  // offset counts words
  assign branchTarget = pcPlus4 + {branchOffset[29:0], 2'b00};
  // keep the 256 MB region of pc+4
  assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00};
  assign branchTaken  = ctrl.branch & aluZero;

  // ==================================================
  // address register
  // ==================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else if (ctrl.jump) begin
      pcReg <= jumpTarget;
    end else if (branchTaken) begin
      pcReg <= branchTarget;
    end else begin
      pcReg <= pcPlus4;
    end
  end

  assign pc = pcReg;

endmodule

// ==== hdl/controlDecoder.sv ====
/*
 * Main control and ALU control in one combinational block.
 * Maps opcode and function code of the fetched word onto the
 * control struct read by the rest of the core.
 */
`timescale 1ns/1ps
`include "mips_macros.svh"

module controlDecoder import mipsPkg::*; (
  input  word_t    instr,
  output ctrlSig_t ctrl
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  // ==================================================
  // decode
  // ==================================================
  always_comb begin
    // unknown opcodes fall through as a no-op
    ctrl         = '0;
    ctrl.aluCtrl = `ALU_NOP;

    case (opcode)
      `OP_RTYPE: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          `FN_ADD: ctrl.aluCtrl = `ALU_ADD;
          `FN_SUB: ctrl.aluCtrl = `ALU_SUB;
          `FN_AND: ctrl.aluCtrl = `ALU_AND;
          `FN_OR:  ctrl.aluCtrl = `ALU_OR;
          `FN_SLT: ctrl.aluCtrl = `ALU_SLT;
          default: begin
            // unsupported funct, nothing written
            ctrl.regWrite = 1'b0;
          end
        endcase
      end
      `OP_LW: begin
        // address = rs + offset
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluCtrl  = `ALU_ADD;
      end
      `OP_SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluCtrl  = `ALU_ADD;
      end
      `OP_BEQ: begin
        // compare by subtraction, zero flag decides
        ctrl.branch  = 1'b1;
        ctrl.aluCtrl = `ALU_SUB;
      end
      `OP_J: begin
        ctrl.jump = 1'b1;
      end
      `OP_JAL: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        ctrl.aluCtrl = `ALU_NOP;
      end
    endcase
  end

endmodule

// ==== hdl/mipsPkg.sv ====
/*
 * Types shared by the core blocks and the testbench.
 * Import with a wildcard in the module header of each user.
 */
package mipsPkg;

  // data and address word
  typedef logic [31:0] word_t;

  // register number, rs/rt/rd fields
  typedef logic [4:0] regAddr_t;

  // ALU operation, values from the macro header
  typedef logic [3:0] aluCtrl_t;

  // ==================================================
  // decoded controls of one instruction
  // ==================================================
  typedef struct packed {
    // destination from rd instead of rt
    logic     regDst;
    // jal: write pc+8 into r31
    logic     link;
    // second operand is the immediate
    logic     aluSrc;
    // write back load data
    logic     memToReg;
    logic     regWrite;
    logic     memWrite;
    // beq
    logic     branch;
    // j or jal
    logic     jump;
    aluCtrl_t aluCtrl;
  } ctrlSig_t;

  // twelve bits total, first field at the top

endpackage

// ==== hdl/mips_macros.svh ====
/*
 * Encodings shared by the single-cycle MIPS core.
 * Opcodes, R-type function codes, ALU operation codes, the link
 * register number and the data memory word-address width.
 * Include wherever one of these constants is needed.
 */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// ==================================================
// primary opcodes, instr[31:26]
// ==================================================
`define OP_RTYPE 6'b000000
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_BEQ   6'b000100
`define OP_LW    6'b100011
`define OP_SW    6'b101011

// R-type function codes, instr[5:0]
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR  6'b100101
`define FN_SLT 6'b101010

// ==================================================
// ALU operation codes
// ==================================================
`define ALU_AND 4'b0000
`define ALU_OR  4'b0001
`define ALU_ADD 4'b0010
`define ALU_SUB 4'b0110
`define ALU_SLT 4'b0111
// no-op, result forced to zero
`define ALU_NOP 4'b1111

// jal return address goes here
`define LINK_REG 5'd31
// data memory is addressed by word
`define DMEM_ADDR_W 7

`endif
